// ==== include/conv1d_defines.svh ====
`ifndef CONV1D_DEFINES_SVH
`define CONV1D_DEFINES_SVH

// samples accepted per frame
`define CONV_FRAME_LEN 64

// filter length
`define CONV_TAPS 33

// outputs computed side by side in one pass
`define CONV_LANES 16

// valid convolution outputs, 32 for this layer
`define CONV_OUT_LEN (`CONV_FRAME_LEN - `CONV_TAPS + 1)

// width of samples, coefficients and results
`define CONV_SAMPLE_W 16

`endif

// ==== logic/conv1d_pkg.sv ====
`include "conv1d_defines.svh"

package conv1d_pkg;

	typedef logic signed [`CONV_SAMPLE_W-1:0] sample_t;

	// wide enough for a full product plus a 16 bit addend without overflow
	typedef logic signed [2*`CONV_SAMPLE_W+1:0] prod_t;

	typedef logic [5:0] x_addr_t; // sample buffer index
	typedef logic [4:0] y_addr_t; // result buffer index
	typedef logic [5:0] tap_t;

	// layer one filter, tap 0 first
	localparam sample_t coef_table [`CONV_TAPS] = '{
		-16'sd129, 16'sd252, 16'sd145, 16'sd88, 16'sd253, -16'sd113,
		16'sd127, -16'sd16, -16'sd129, 16'sd116, -16'sd127, 16'sd79,
		-16'sd218, -16'sd40, 16'sd206, -16'sd190, 16'sd120, -16'sd182,
		-16'sd107, -16'sd238, -16'sd133, -16'sd224, -16'sd124, 16'sd180,
		16'sd210, 16'sd85, 16'sd252, -16'sd123, 16'sd118, -16'sd198,
		16'sd50, 16'sd245, -16'sd202
	};

	// clamp to the signed 16 bit range
	function automatic sample_t sat16(prod_t v);
		prod_t max_v;
		prod_t min_v;
		max_v = prod_t'(32767);
		min_v = prod_t'(-32768);
		if (v > max_v) begin
			return sample_t'(32767);
		end
		else if (v < min_v) begin
			return sample_t'(-32768);
		end
		return sample_t'(v);
	endfunction

endpackage

// ==== logic/sample_buffer.sv ====
`timescale 1ns/1ps
`include "conv1d_defines.svh"

module sample_buffer (
	input  logic                clk,
	input  logic                wr_en,
	input  conv1d_pkg::x_addr_t wr_addr,
	input  conv1d_pkg::sample_t data_in,
	input  conv1d_pkg::x_addr_t rd_base,
	output conv1d_pkg::sample_t lane_x [`CONV_LANES]
);

	conv1d_pkg::sample_t mem [`CONV_FRAME_LEN];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= data_in;
		end
	end

	// one read port per lane, each offset by its lane index
	always_ff @(posedge clk) begin
		for (int i = 0; i < `CONV_LANES; i++) begin
			lane_x[i] <= mem[conv1d_pkg::x_addr_t'(rd_base + i)]; // wraps past the end, unused then
		end
	end

endmodule

// ==== logic/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane (
	input  logic                clk,
	input  logic                reset,
	input  conv1d_pkg::sample_t x,
	input  conv1d_pkg::sample_t coef,
	input  logic                acc_clear,
	input  logic                acc_en,
	output conv1d_pkg::sample_t y
);

	conv1d_pkg::prod_t   full_prod;
	conv1d_pkg::prod_t   sum;
	conv1d_pkg::sample_t prod;
	conv1d_pkg::sample_t acc;

	assign full_prod = conv1d_pkg::prod_t'(x) * conv1d_pkg::prod_t'(coef);

	// first tap of an output starts from zero
	assign sum = (acc_clear ? '0 : conv1d_pkg::prod_t'(acc)) + conv1d_pkg::prod_t'(prod);

	always_ff @(posedge clk) begin
		prod <= conv1d_pkg::sat16(full_prod); // product saturates before it is summed
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end
		else if (acc_en) begin
			acc <= conv1d_pkg::sat16(sum);
		end
	end

	// relu
	assign y = (acc < 0) ? '0 : acc;

endmodule

// ==== logic/conv_control.sv ====
`timescale 1ns/1ps
`include "conv1d_defines.svh"

module conv_control (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	output logic                in_ready,
	output logic                out_valid,
	input  logic                out_ready,
	output logic                wr_en,
	output conv1d_pkg::x_addr_t wr_addr,
	output conv1d_pkg::x_addr_t rd_base,
	output conv1d_pkg::sample_t coef,
	output logic                acc_clear,
	output logic                acc_en,
	output logic                y_wr_en,
	output conv1d_pkg::y_addr_t y_base,
	output conv1d_pkg::y_addr_t y_rd_addr
);

	typedef enum logic [1:0] {
		LOAD,
		COMPUTE,
		DRAIN
	} state_t;

	// a pass is 33 taps, two fill cycles, one write cycle and one spare
	localparam conv1d_pkg::tap_t write_step = conv1d_pkg::tap_t'(`CONV_TAPS + 2);
	localparam conv1d_pkg::tap_t last_step = conv1d_pkg::tap_t'(`CONV_TAPS + 3);

	state_t              state;
	conv1d_pkg::x_addr_t x_cnt;
	conv1d_pkg::y_addr_t out_cnt;
	conv1d_pkg::tap_t    step;
	logic                pass;
	logic                tap_active;
	logic                tap_d1;
	logic                tap_d2;
	logic                first_d1;
	logic                first_d2;

	assign in_ready = (state == LOAD);
	assign out_valid = (state == DRAIN);
	assign wr_en = in_valid && in_ready;
	assign wr_addr = x_cnt;
	assign y_rd_addr = out_cnt;

	assign tap_active = (state == COMPUTE) && (step < `CONV_TAPS);
	assign rd_base = conv1d_pkg::x_addr_t'(pass * `CONV_LANES) + step;

	assign y_wr_en = (state == COMPUTE) && (step == write_step); // one cycle after last accumulate
	assign y_base = conv1d_pkg::y_addr_t'(pass * `CONV_LANES);

	assign acc_en = tap_d2;
	assign acc_clear = first_d2;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LOAD;
			x_cnt <= '0;
			out_cnt <= '0;
			step <= '0;
			pass <= 1'b0;
		end
		else begin
			case (state)
				LOAD: begin
					if (wr_en) begin
						if (x_cnt == `CONV_FRAME_LEN - 1) begin
							x_cnt <= '0;
							state <= COMPUTE;
						end
						else begin
							x_cnt <= x_cnt + 1'b1;
						end
					end
				end
				COMPUTE: begin
					if (step == last_step) begin
						step <= '0;
						if (pass) begin // both halves written
							pass <= 1'b0;
							state <= DRAIN;
						end
						else begin
							pass <= 1'b1;
						end
					end
					else begin
						step <= step + 1'b1;
					end
				end
				DRAIN: begin
					if (out_ready) begin
						if (out_cnt == `CONV_OUT_LEN - 1) begin
							out_cnt <= '0;
							state <= LOAD;
						end
						else begin
							out_cnt <= out_cnt + 1'b1;
						end
					end
				end
				default: state <= LOAD;
			endcase
		end
	end

	// buffer read and coef register, then the product register
	always_ff @(posedge clk) begin
		if (reset) begin
			tap_d1 <= 1'b0;
			tap_d2 <= 1'b0;
			first_d1 <= 1'b0;
			first_d2 <= 1'b0;
		end
		else begin
			tap_d1 <= tap_active;
			tap_d2 <= tap_d1;
			first_d1 <= tap_active && (step == '0);
			first_d2 <= first_d1;
		end
	end

	always_ff @(posedge clk) begin
		if (tap_active) begin
			coef <= conv1d_pkg::coef_table[step];
		end
	end

endmodule

// ==== logic/result_buffer.sv ====
`timescale 1ns/1ps
`include "conv1d_defines.svh"

module result_buffer (
	input  logic                clk,
	input  logic                y_wr_en,
	input  conv1d_pkg::y_addr_t y_base,
	input  conv1d_pkg::sample_t lane_y [`CONV_LANES],
	input  conv1d_pkg::y_addr_t y_rd_addr,
	output conv1d_pkg::sample_t data_out
);

	conv1d_pkg::sample_t mem [`CONV_OUT_LEN];

	// a whole pass lands in one write
	always_ff @(posedge clk) begin
		if (y_wr_en) begin
			for (int i = 0; i < `CONV_LANES; i++) begin
				mem[conv1d_pkg::y_addr_t'(y_base + i)] <= lane_y[i];
			end
		end
	end

	assign data_out = mem[y_rd_addr]; // read straight through

endmodule

// ==== logic/conv1d_layer.sv ====
`timescale 1ns/1ps
`include "conv1d_defines.svh"

module conv1d_layer (
	input  logic                clk,
	input  logic                reset,
	input  conv1d_pkg::sample_t data_in,
	input  logic                in_valid,
	output logic                in_ready,
	output conv1d_pkg::sample_t data_out,
	output logic                out_valid,
	input  logic                out_ready
);

	logic                wr_en;
	conv1d_pkg::x_addr_t wr_addr;
	conv1d_pkg::x_addr_t rd_base;
	conv1d_pkg::sample_t coef;
	logic                acc_clear;
	logic                acc_en;
	logic                y_wr_en;
	conv1d_pkg::y_addr_t y_base;
	conv1d_pkg::y_addr_t y_rd_addr;
	conv1d_pkg::sample_t lane_x [`CONV_LANES];
	conv1d_pkg::sample_t lane_y [`CONV_LANES];

	conv_control ctrl0 (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.rd_base   (rd_base),
		.coef      (coef),
		.acc_clear (acc_clear),
		.acc_en    (acc_en),
		.y_wr_en   (y_wr_en),
		.y_base    (y_base),
		.y_rd_addr (y_rd_addr)
	);

	sample_buffer xbuf0 (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.data_in (data_in),
		.rd_base (rd_base),
		.lane_x  (lane_x)
	);

	for (genvar i = 0; i < `CONV_LANES; i++) begin : g_lane
		mac_lane lane0 (
			.clk       (clk),
			.reset     (reset),
			.x         (lane_x[i]),
			.coef      (coef),
			.acc_clear (acc_clear),
			.acc_en    (acc_en),
			.y         (lane_y[i])
		);
	end

	result_buffer ybuf0 (
		.clk       (clk),
		.y_wr_en   (y_wr_en),
		.y_base    (y_base),
		.lane_y    (lane_y),
		.y_rd_addr (y_rd_addr),
		.data_out  (data_out)
	);

endmodule

// ==== bench/conv1d_checker.sv ====
`timescale 1ns/1ps
`include "conv1d_defines.svh"

module conv1d_checker (
	input  logic                clk,
	input  logic                reset,
	input  conv1d_pkg::sample_t data_in,
	input  logic                in_valid,
	input  logic                in_ready,
	input  conv1d_pkg::sample_t data_out,
	input  logic                out_valid,
	input  logic                out_ready,
	input  int                  test_id,
	input  logic                test_end,
	input  logic                run_done,
	output int                  errors
);

	conv1d_pkg::sample_t xs [$];    // accepted samples of the frame being loaded
	conv1d_pkg::sample_t exp_q [$]; // expected words still to come out
	conv1d_pkg::sample_t held_val;
	logic                busy;
	logic                held;
	logic                just_drained;
	logic                after_reset;
	int                  out_cnt;
	int                  checks;
	int                  tests;
	int                  test_checks;
	int                  test_errors;

	function automatic int clamp16(int v);
		if (v > 32767) begin
			return 32767;
		end
		if (v < -32768) begin
			return -32768;
		end
		return v;
	endfunction

	// taps summed in order, both product and running sum clamped, relu at the end
	task automatic build_expected();
		int acc;
		for (int j = 0; j < `CONV_OUT_LEN; j++) begin
			acc = 0;
			for (int t = 0; t < `CONV_TAPS; t++) begin
				acc = clamp16(acc + clamp16(int'(xs[j + t]) * int'(conv1d_pkg::coef_table[t])));
			end
			exp_q.push_back(conv1d_pkg::sample_t'((acc < 0) ? 0 : acc));
		end
		xs.delete();
	endtask

	task automatic log_error(string line);
		$display("%s", line);
		errors++;
		test_errors++;
	endtask

	task automatic count_check();
		checks++;
		test_checks++;
	endtask

	initial begin
		errors = 0;
		checks = 0;
		tests = 0;
		test_checks = 0;
		test_errors = 0;
		busy = 1'b0;
		held = 1'b0;
		just_drained = 1'b0;
		after_reset = 1'b0;
		out_cnt = 0;
	end

	always @(posedge clk) begin
		if (reset) begin
			xs.delete();
			exp_q.delete();
			busy = 1'b0;
			held = 1'b0;
			just_drained = 1'b0;
			out_cnt = 0;
			after_reset = 1'b1;
		end
		else begin
			if (after_reset) begin
				count_check();
				if (!in_ready || out_valid) begin
					log_error("after reset in_ready was not 1 or out_valid was not 0");
				end
				after_reset = 1'b0;
			end
			if (just_drained) begin
				count_check();
				if (!in_ready || out_valid) begin
					log_error("after the last word the layer did not go back to loading");
				end
				just_drained = 1'b0;
			end
			if (held) begin
				count_check();
				if (!out_valid) begin
					log_error("out_valid fell before the stalled word was taken");
				end
				else if (data_out !== held_val) begin
					log_error($sformatf("FAIL data_out while stalled: expected %h, got %h",
						held_val, data_out));
				end
				held = 1'b0;
			end
			if (busy && in_ready) begin
				log_error("in_ready high while a frame was still being processed");
			end
			if (!busy && out_valid) begin
				log_error("out_valid high with no frame computed");
			end
			if (in_valid && in_ready) begin
				xs.push_back(data_in);
				if (xs.size() == `CONV_FRAME_LEN) begin
					build_expected();
					busy = 1'b1;
				end
			end
			else if (busy && out_valid && out_ready) begin
				count_check();
				if (data_out !== exp_q[0]) begin
					log_error($sformatf("FAIL data_out word %0d: expected %h, got %h",
						out_cnt, exp_q[0], data_out));
				end
				void'(exp_q.pop_front());
				out_cnt++;
				if (out_cnt == `CONV_OUT_LEN) begin
					busy = 1'b0;
					out_cnt = 0;
					just_drained = 1'b1;
				end
			end
			else if (busy && out_valid) begin
				held = 1'b1; // word must hold through the stall
				held_val = data_out;
			end
			if (test_end) begin
				tests++;
				$display("test %0d %s: %0d checks, %0d errors", test_id,
					(test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
			if (run_done) begin
				$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			end
		end
	end

endmodule

// ==== bench/conv1d_tb.sv ====
`timescale 1ns/1ps
`include "conv1d_defines.svh"

module conv1d_tb;

	localparam int num_frames = 7;
	localparam int clk_period = 100;
	localparam int drive_delay = 1;
	localparam int timeout_ns = num_frames * 600 * clk_period * 2;

	logic                clk;
	logic                reset;
	conv1d_pkg::sample_t data_in;
	logic                in_valid;
	logic                in_ready;
	conv1d_pkg::sample_t data_out;
	logic                out_valid;
	logic                out_ready;
	int                  test_id;
	logic                test_end;
	logic                run_done;
	int                  errors;
	logic [15:0]         lfsr_state;

	conv1d_layer dut0 (
		.clk       (clk),
		.reset     (reset),
		.data_in   (data_in),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.data_out  (data_out),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	conv1d_checker chk0 (
		.clk       (clk),
		.reset     (reset),
		.data_in   (data_in),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.data_out  (data_out),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.test_id   (test_id),
		.test_end  (test_end),
		.run_done  (run_done),
		.errors    (errors)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// full range leans on the rails so products and sums clip
	function automatic conv1d_pkg::sample_t make_sample(logic full_range);
		logic [31:0] r;
		if (!full_range) begin
			r = rand_bits(8);
			return {{8{r[7]}}, r[7:0]};
		end
		r = rand_bits(2);
		if (r[1:0] == 2'd0) begin
			return conv1d_pkg::sample_t'(32767 - rand_bits(4));
		end
		if (r[1:0] == 2'd1) begin
			return conv1d_pkg::sample_t'(16'h8000 + rand_bits(4));
		end
		return conv1d_pkg::sample_t'(rand_bits(16));
	endfunction

	task automatic load_frame(logic full_range, logic gaps, logic junk);
		int accepted;
		accepted = 0;
		while (accepted < `CONV_FRAME_LEN) begin
			in_valid = gaps ? (rand_bits(2) != 0) : 1'b1;
			data_in = make_sample(full_range);
			if (in_valid && in_ready) begin
				accepted++;
			end
			@(posedge clk);
			#drive_delay;
		end
		in_valid = junk; // keeps offering while the layer is busy
	endtask

	task automatic drain_frame(logic backpressure, logic junk);
		int taken;
		taken = 0;
		while (taken < `CONV_OUT_LEN) begin
			out_ready = backpressure ? (rand_bits(1) != 0) : 1'b1;
			in_valid = junk;
			if (junk) begin
				data_in = make_sample(1'b1);
			end
			if (out_valid && out_ready) begin
				taken++;
			end
			@(posedge clk);
			#drive_delay;
		end
		in_valid = 1'b0;
		out_ready = 1'b0;
	endtask

	task automatic end_test();
		test_end = 1'b1;
		@(posedge clk);
		#drive_delay;
		test_end = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		data_in = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		test_id = 0;
		test_end = 1'b0;
		run_done = 1'b0;
		lfsr_state = 16'd60609;
		repeat (5) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		test_id = 1;
		end_test();
		test_id = 2;
		load_frame(1'b0, 1'b0, 1'b0);
		drain_frame(1'b0, 1'b0);
		end_test();
		test_id = 3;
		load_frame(1'b1, 1'b1, 1'b0);
		drain_frame(1'b0, 1'b0);
		end_test();
		test_id = 4;
		load_frame(1'b1, 1'b0, 1'b0);
		drain_frame(1'b1, 1'b0);
		end_test();
		test_id = 5;
		load_frame(1'b0, 1'b1, 1'b1);
		drain_frame(1'b1, 1'b1);
		end_test();
		test_id = 6;
		repeat (3) begin
			load_frame(1'b1, 1'b0, 1'b0);
			drain_frame(1'b0, 1'b0);
		end
		end_test();
		run_done = 1'b1;
		@(posedge clk);
		#drive_delay;
		if (errors == 0) begin
			$display("Everything OK");
		end
		else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#timeout_ns;
		$display("watchdog expired before all tests finished");
		$display("Something failed");
		$finish;
	end

endmodule

// ==== conv1d.f ====
+incdir+include
logic/conv1d_pkg.sv
logic/sample_buffer.sv
logic/mac_lane.sv
logic/conv_control.sv
logic/result_buffer.sv
logic/conv1d_layer.sv
bench/conv1d_checker.sv
bench/conv1d_tb.sv
